/* nocPkg.sv */
package nocPkg;

  // five directions in the order L, N, E, W, S.
  localparam int numPorts = 5;

  typedef logic [2:0]  flitIdT;
  typedef logic [11:0] lengthT;
  typedef logic [15:0] payloadT;
  typedef logic [18:0] flitT;
  typedef logic [2:0]  portIdT;

  localparam flitIdT headerId = 3'd1;
  localparam flitIdT bodyId   = 3'd2;
  localparam flitIdT tailId   = 3'd3;

  // kind sits above the payload.
  function automatic flitIdT flitKind(input flitT flit);
    return flit[18:16];
  endfunction

  // hold budget rides in the low payload bits of a header.
  function automatic lengthT flitLength(input flitT flit);
    return flit[11:0];
  endfunction

  function automatic flitT makeFlit(input flitIdT kind, input payloadT payload);
    return {kind, payload};
  endfunction

endpackage

/* arbPkg.sv */
package arbPkg;
  import nocPkg::*;

  typedef enum logic [5:0] {
    idle   = 6'b000001,
    grantL = 6'b000010,
    grantN = 6'b000100,
    grantE = 6'b001000,
    grantW = 6'b010000,
    grantS = 6'b100000
  } arbStateT;

  function automatic arbStateT grantOf(input portIdT port);
    case (port)
      3'd0:    return grantL;
      3'd1:    return grantN;
      3'd2:    return grantE;
      3'd3:    return grantW;
      3'd4:    return grantS;
      default: return idle;
    endcase
  endfunction

  // idle maps to L, callers check for idle themselves.
  function automatic portIdT portOf(input arbStateT state);
    case (state)
      grantN:  return 3'd1;
      grantE:  return 3'd2;
      grantW:  return 3'd3;
      grantS:  return 3'd4;
      default: return 3'd0;
    endcase
  endfunction

endpackage

/* flitFifo.sv */
`timescale 1ns/1ps

module flitFifo
  import nocPkg::*;
#(
  parameter int fifoDepth = 4
)
(
  input  logic clk,
  input  logic rst,
  input  logic inValid,
  output logic inReady,
  input  flitT inFlit,
  output logic headValid,
  output flitT headFlit,
  input  logic pop
);

  localparam int ptrW = (fifoDepth > 1) ? $clog2(fifoDepth) : 1;
  localparam int cntW = $clog2(fifoDepth + 1);

  flitT mem [fifoDepth];
  logic [ptrW-1:0] wrPtr;
  logic [ptrW-1:0] rdPtr;
  logic [cntW-1:0] count;
  logic push;
  logic popEn;

  function automatic logic [ptrW-1:0] nextPtr(input logic [ptrW-1:0] ptr);
    return (ptr == ptrW'(fifoDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign inReady   = (count != cntW'(fifoDepth));
  assign headValid = (count != '0);
  assign headFlit  = mem[rdPtr];
  assign push      = inValid && inReady;
  assign popEn     = pop && headValid;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
        wrPtr <= nextPtr(wrPtr);
      if (popEn)
        rdPtr <= nextPtr(rdPtr);
      // simultaneous push and pop leaves the count alone.
      if (push && !popEn)
        count <= count + 1'b1;
      else if (popEn && !push)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wrPtr] <= inFlit;
  end

endmodule

/* holdTimer.sv */
`timescale 1ns/1ps

module holdTimer
  import nocPkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic headValid,
  input  flitT headFlit,
  input  logic run,
  output logic expired
);

  lengthT limit;
  lengthT count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      if (headValid && flitKind(headFlit) == headerId)
        limit <= flitLength(headFlit);
      if (run)
        count <= count + 1'b1;
      else
        count <= '0;
    end
  end

  // at or past the limit, so a shorter header mid-grant still ends it.
  assign expired = (count >= limit);

endmodule

/* outputArbiter.sv */
`timescale 1ns/1ps

module outputArbiter
  import nocPkg::*;
  import arbPkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic [numPorts-1:0] headValid,
  input  flitT                headFlit [numPorts],
  output arbStateT            grantState
);

  arbStateT nextState;
  portIdT holder;
  portIdT startPort;
  portIdT candidate;
  logic keep;
  logic found;
  logic [numPorts-1:0] run;
  logic [numPorts-1:0] expired;

  for (genvar p = 0; p < numPorts; p++)
  begin : timerGen
    holdTimer timer0 (
      .clk       (clk),
      .rst       (rst),
      .headValid (headValid[p]),
      .headFlit  (headFlit[p]),
      .run       (run[p]),
      .expired   (expired[p])
    );

    // only counts while the holder stays on its own budget.
    assign run[p] = keep && (grantState == grantOf(portIdT'(p)));
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      grantState <= idle;
    else
      grantState <= nextState;
  end

  assign holder = portOf(grantState);

  // search begins one past the holder, or at L from idle.
  always_comb
  begin
    if (grantState == idle)
      startPort = 3'd0;
    else if (holder == portIdT'(numPorts - 1))
      startPort = 3'd0;
    else
      startPort = holder + 1'b1;
  end

  always_comb
  begin
    nextState = idle;
    keep      = 1'b0;
    found     = 1'b0;
    candidate = '0;
    if (grantState != idle && headValid[holder] && !expired[holder])
    begin
      nextState = grantState;
      keep      = 1'b1;
    end
    else
    begin
      // the holder itself comes last in the cyclic order.
      for (int i = 0; i < numPorts; i++)
      begin
        candidate = portIdT'((int'(startPort) + i) % numPorts);
        if (!found && headValid[candidate])
        begin
          nextState = grantOf(candidate);
          found     = 1'b1;
        end
      end
    end
  end

endmodule

/* switchOutput.sv */
`timescale 1ns/1ps

module switchOutput
  import nocPkg::*;
  import arbPkg::*;
(
  input  arbStateT            grantState,
  input  logic [numPorts-1:0] headValid,
  input  flitT                headFlit [numPorts],
  output logic [numPorts-1:0] pop,
  output logic                outValid,
  input  logic                outReady,
  output flitT                outFlit,
  output portIdT              outPort
);

  portIdT sel;
  logic granted;
  logic transfer;

  assign sel     = portOf(grantState);
  assign granted = (grantState != idle);

  assign outValid = granted && headValid[sel];
  assign outFlit  = headFlit[sel];
  assign outPort  = sel;

  assign transfer = outValid && outReady;

  // only the granted buffer sees a pop.
  always_comb
  begin
    for (int p = 0; p < numPorts; p++)
      pop[p] = transfer && (sel == portIdT'(p));
  end

endmodule

/* routerOutputStage.sv */
`timescale 1ns/1ps

module routerOutputStage
  import nocPkg::*;
#(
  parameter int fifoDepth = 4
)
(
  input  logic                clk,
  input  logic                rst,
  input  logic [numPorts-1:0] inValid,
  output logic [numPorts-1:0] inReady,
  input  flitT                inFlit [numPorts],
  output logic                outValid,
  input  logic                outReady,
  output flitT                outFlit,
  output portIdT              outPort
);

  logic [numPorts-1:0] headValid;
  flitT headFlit [numPorts];
  logic [numPorts-1:0] pop;
  arbPkg::arbStateT grantState;

  // one input buffer per direction.
  for (genvar p = 0; p < numPorts; p++)
  begin : bufferGen
    flitFifo #(
      .fifoDepth (fifoDepth)
    ) fifo0 (
      .clk       (clk),
      .rst       (rst),
      .inValid   (inValid[p]),
      .inReady   (inReady[p]),
      .inFlit    (inFlit[p]),
      .headValid (headValid[p]),
      .headFlit  (headFlit[p]),
      .pop       (pop[p])
    );
  end

  outputArbiter arbiter0 (
    .clk        (clk),
    .rst        (rst),
    .headValid  (headValid),
    .headFlit   (headFlit),
    .grantState (grantState)
  );

  switchOutput switch0 (
    .grantState (grantState),
    .headValid  (headValid),
    .headFlit   (headFlit),
    .pop        (pop),
    .outValid   (outValid),
    .outReady   (outReady),
    .outFlit    (outFlit),
    .outPort    (outPort)
  );

endmodule

/* routerOutputStage_assertions.sv */
`timescale 1ns/1ps

module routerOutputStage_assertions
  import nocPkg::*;
  import arbPkg::*;
#(
  parameter int fifoDepth = 4
)
(
  input logic                clk,
  input logic                rst,
  input logic [numPorts-1:0] inValid,
  input logic [numPorts-1:0] inReady,
  input flitT                inFlit [numPorts],
  input logic                outValid,
  input logic                outReady,
  input flitT                outFlit,
  input portIdT              outPort
);

  // reference queues of accepted flits, one per direction.
  flitT queue [numPorts][$];
  flitT front [numPorts];
  int fill [numPorts];
  lengthT limit [numPorts];
  logic [numPorts-1:0] pending;
  logic othersReq;
  portIdT rotNext;
  int runLen;
  int heldCycles;
  logic lastValid;
  logic lastStall;
  logic lastForced;
  portIdT lastPort;
  portIdT lastRot;
  flitT lastFlit;
  int errCount = 0;

  always @(posedge clk)
  begin
    if (rst)
    begin
      for (int p = 0; p < numPorts; p++)
      begin
        queue[p].delete();
        limit[p] <= '0;
      end
      lastValid  <= 1'b0;
      lastStall  <= 1'b0;
      lastForced <= 1'b0;
      heldCycles <= 0;
    end
    else
    begin
      for (int p = 0; p < numPorts; p++)
      begin
        // a header sitting at a valid head reloads the budget.
        if (pending[p] && front[p][18:16] == headerId)
          limit[p] <= front[p][11:0];
        if (inValid[p] && inReady[p])
          queue[p].push_back(inFlit[p]);
      end
      if (outValid && outReady && pending[outPort])
        void'(queue[outPort].pop_front());
      lastValid  <= outValid;
      lastStall  <= outValid && !outReady;
      lastForced <= runLen > int'(limit[outPort]);
      lastPort   <= outPort;
      lastFlit   <= outFlit;
      lastRot    <= rotNext;
      heldCycles <= runLen;
    end
    for (int p = 0; p < numPorts; p++)
    begin
      pending[p] <= queue[p].size() != 0;
      front[p]   <= (queue[p].size() != 0) ? queue[p][0] : '0;
      fill[p]    <= queue[p].size();
    end
  end

  // cycles in a row that one direction has held the output while others wait.
  always_comb
  begin
    othersReq = 1'b0;
    for (int p = 0; p < numPorts; p++)
      if (pending[p] && p != int'(outPort))
        othersReq = 1'b1;
    if (!(outValid && othersReq))
      runLen = 0;
    else if (heldCycles != 0 && lastPort == outPort)
      runLen = heldCycles + 1;
    else
      runLen = 1;
  end

  // scan from far to near so the nearest requester after the holder wins.
  always_comb
  begin
    rotNext = outPort;
    for (int i = numPorts - 1; i >= 1; i--)
      if (pending[(int'(outPort) + i) % numPorts])
        rotNext = portIdT'((int'(outPort) + i) % numPorts);
  end

  assert property (@(posedge clk) disable iff (rst)
    outValid && outReady |-> pending[outPort] && outFlit == front[outPort])
  else
  begin
    errCount++;
    $error("ERROR %0t outFlit expected %h actual %h", $time,
      $sampled(front[outPort]), $sampled(outFlit));
  end

  assert property (@(posedge clk) rst |=> !outValid && inReady == '1)
  else
  begin
    errCount++;
    $error("the outputs were not idle right after reset");
  end

  assert property (@(posedge clk) disable iff (rst) pending == '0 |-> !outValid)
  else
  begin
    errCount++;
    $error("outValid was high while every buffer was empty");
  end

  assert property (@(posedge clk) disable iff (rst)
    lastStall |-> outValid && (outPort != lastPort || outFlit == lastFlit))
  else
  begin
    errCount++;
    $error("ERROR %0t outFlit expected %h actual %h while stalled, outValid %b", $time,
      $sampled(lastFlit), $sampled(outFlit), $sampled(outValid));
  end

  assert property (@(posedge clk) disable iff (rst)
    lastValid && outValid && outPort != lastPort |-> outPort == lastRot)
  else
  begin
    errCount++;
    $error("ERROR %0t outPort expected %0d actual %0d", $time,
      $sampled(lastRot), $sampled(outPort));
  end

  assert property (@(posedge clk) disable iff (rst)
    lastForced |-> outValid && outPort != lastPort)
  else
  begin
    errCount++;
    $error("direction %0d kept the grant past its hold budget", $sampled(lastPort));
  end

  for (genvar p = 0; p < numPorts; p++)
  begin : fullGen
    assert property (@(posedge clk) disable iff (rst) inReady[p] == (fill[p] < fifoDepth))
    else
    begin
      errCount++;
      $error("ERROR %0t inReady[%0d] expected %b actual %b", $time, p,
        $sampled(fill[p] < fifoDepth), $sampled(inReady[p]));
    end
  end

endmodule

bind routerOutputStage routerOutputStage_assertions #(
  .fifoDepth (fifoDepth)
) chk0 (
  .clk      (clk),
  .rst      (rst),
  .inValid  (inValid),
  .inReady  (inReady),
  .inFlit   (inFlit),
  .outValid (outValid),
  .outReady (outReady),
  .outFlit  (outFlit),
  .outPort  (outPort)
);

/* routerOutputStageTb.sv */
`timescale 1ns/1ps

module routerOutputStageTb
  import nocPkg::*;
();

  localparam int waitLimit = 400;

  logic clk = 1'b0;
  logic rst;
  logic [numPorts-1:0] inValid;
  logic [numPorts-1:0] inReady;
  flitT inFlit [numPorts];
  logic outValid;
  logic outReady;
  flitT outFlit;
  portIdT outPort;

  integer seed = 32'h79fe;
  int readyMode = 0;
  int sent = 0;
  int received = 0;
  int testCount = 0;
  int seqNum [numPorts];
  logic xferNext = 1'b0;

  always #10 clk = ~clk;

  routerOutputStage #(
    .fifoDepth (4)
  ) dut0 (
    .clk      (clk),
    .rst      (rst),
    .inValid  (inValid),
    .inReady  (inReady),
    .inFlit   (inFlit),
    .outValid (outValid),
    .outReady (outReady),
    .outFlit  (outFlit),
    .outPort  (outPort)
  );

  task automatic abortRun(input string why);
    $display("timeout at %0t: %s", $time, why);
    $display("Finished with errors");
    $finish;
  endtask

  task automatic sendFlit(input int p, input flitT flit);
    int cycles;
    cycles = 0;
    inValid[p] = 1'b1;
    inFlit[p]  = flit;
    while (!inReady[p])
    begin
      @(posedge clk);
      #2;
      cycles++;
      if (cycles > waitLimit)
        abortRun($sformatf("direction %0d never accepted a flit", p));
    end
    @(posedge clk);
    #2;
    inValid[p] = 1'b0;
    sent++;
  endtask

  // header carries the length, body and tail carry a sequence number.
  task automatic sendPackets(input int p, input int count);
    lengthT len;
    int bodies;
    for (int k = 0; k < count; k++)
    begin
      len    = lengthT'($unsigned($random(seed)) % 7);
      bodies = $unsigned($random(seed)) % 4;
      sendFlit(p, makeFlit(headerId, {portIdT'(p), 1'b0, len}));
      for (int b = 0; b <= bodies; b++)
      begin
        sendFlit(p, makeFlit((b == bodies) ? tailId : bodyId,
          {portIdT'(p), 13'(seqNum[p])}));
        seqNum[p]++;
      end
    end
  endtask

  task automatic sendAll(input int count);
    fork
      sendPackets(0, count);
      sendPackets(1, count);
      sendPackets(2, count);
      sendPackets(3, count);
      sendPackets(4, count);
    join
  endtask

  task automatic waitFor(input bit allFull);
    int cycles;
    cycles = 0;
    while (allFull ? (inReady != '0) : (received != sent))
    begin
      @(posedge clk);
      #2;
      cycles++;
      if (cycles > waitLimit)
        abortRun(allFull ? "the input buffers never all filled up" :
          "the output never delivered every accepted flit");
    end
  endtask

  task automatic finishTest(input string name);
    testCount++;
    $display("test %0d %s done, errors so far %0d", testCount, name, dut0.chk0.errCount);
  endtask

  // mode 1 stalls the output and mode 2 keeps it ready, anything else is random.
  initial
  begin
    outReady = 1'b0;
    forever
    begin
      @(posedge clk);
      if (xferNext)
        received++;
      #2;
      case (readyMode)
        1:       outReady = 1'b0;
        2:       outReady = 1'b1;
        default: outReady = ($random(seed) % 4) != 0;
      endcase
      xferNext = outValid && outReady;
    end
  end

  initial
  begin
    rst     = 1'b1;
    inValid = '0;
    for (int p = 0; p < numPorts; p++)
    begin
      inFlit[p] = '0;
      seqNum[p] = 0;
    end
    repeat (16) @(posedge clk);
    #2;
    rst = 1'b0;
    finishTest("reset");
    sendAll(6);
    waitFor(1'b0);
    finishTest("random traffic");
    readyMode = 1;
    fork
      sendAll(3);
      begin
        waitFor(1'b1);
        repeat (12) @(posedge clk);
        #1;
        readyMode = 0;
      end
    join
    waitFor(1'b0);
    finishTest("full buffers");
    readyMode = 2;
    sendAll(4);
    waitFor(1'b0);
    finishTest("steady flow");
    $display("tests %0d, flits sent %0d, received %0d, errors %0d",
      testCount, sent, received, dut0.chk0.errCount);
    if (dut0.chk0.errCount == 0 && sent == received)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

/* sim.f */
nocPkg.sv
arbPkg.sv
flitFifo.sv
holdTimer.sv
outputArbiter.sv
switchOutput.sv
routerOutputStage.sv
routerOutputStage_assertions.sv
routerOutputStageTb.sv
